// ==== usb_tele.f ====
hdl/usb_tele_pkg.sv
hdl/telemetry_buffer.sv
hdl/dump_sequencer.sv
hdl/baud_timer.sv
hdl/uart_tx.sv
hdl/usb_tele_top.sv
testbench/tb_usb_tele.sv

// ==== Bender.yml ====
package:
  name: usb_tele

sources:
  - hdl/usb_tele_pkg.sv
  - hdl/telemetry_buffer.sv
  - hdl/dump_sequencer.sv
  - hdl/baud_timer.sv
  - hdl/uart_tx.sv
  - hdl/usb_tele_top.sv
  - target: simulation
    files:
      - testbench/tb_usb_tele.sv

// ==== testbench/tb_usb_tele.sv ====
`timescale 1ns/10ps
module tb_usb_tele;
  import usb_tele_pkg::*;

  localparam int FRAME_CYCLES = FRAME_BITS * CYCLES_PER_BIT;
  localparam int GAP_LIMIT = 4 * FRAME_CYCLES;  // Longest quiet line inside a dump

  logic clock = 1'b0;
  logic usb_reset;
  logic sample_i, start_i;
  logic [3:0] phy_state_i, ctl_state_i, usb_state_i, tok_endpt_i;
  logic [7:0] blk_state_i;
  logic [2:0] err_code_i;
  logic [1:0] line_state_i;
  logic crc_error_i, usb_sof_i, timeout_i;
  logic txd_o, dumping_o;
  level_t level_o;

  integer seed = 81;
  logic [31:0] model_q[$];  // Words the buffer should hold
  byte_t exp_chars[$];  // Characters still owed on txd_o

  always #50 clock = ~clock;

  usb_tele_top u_usb_tele_top (
    .clock(clock), .usb_reset(usb_reset), .sample_i(sample_i),
    .phy_state_i(phy_state_i), .ctl_state_i(ctl_state_i), .blk_state_i(blk_state_i),
    .crc_error_i(crc_error_i), .err_code_i(err_code_i), .usb_state_i(usb_state_i),
    .usb_sof_i(usb_sof_i), .timeout_i(timeout_i), .tok_endpt_i(tok_endpt_i),
    .line_state_i(line_state_i), .start_i(start_i),
    .txd_o(txd_o), .dumping_o(dumping_o), .level_o(level_o)
  );

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic flag_mismatch(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    stop_with_failure();
  endtask

  task automatic abort_on_stall(input string what);
    $display("Timed out while %s", what);
    stop_with_failure();
  endtask

  task automatic report_framing(input string what);
    $display("Bad UART frame on txd_o: %s", what);
    stop_with_failure();
  endtask

  task automatic check_char(input byte_t got, input byte_t exp);
    if (got !== exp) flag_mismatch($sformatf("txd_o char 0x%02h, expected 0x%02h", got, exp));
  endtask

  task automatic check_level(input level_t got, input level_t exp, input string what);
    if (got !== exp) flag_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) flag_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  // Eight upper-case hex digits from the MS nibble down and a line feed
  function automatic logic [71:0] expected_text(input logic [31:0] word);
    logic [71:0] text;
    logic [3:0] nib;
    for (int i = 0; i < 8; i++) begin
      nib = word[31-4*i -: 4];
      text[71-8*i -: 8] = (nib < 4'd10) ? 8'h30 + nib : 8'h41 + (nib - 4'd10);
    end
    text[7:0] = 8'h0A;
    return text;
  endfunction

  // Called at the first low sample of a start bit
  task automatic receive_byte(output byte_t rx);
    repeat (CYCLES_PER_BIT / 2) @(negedge clock);
    if (txd_o !== 1'b0) report_framing("start bit too short");
    for (int i = 0; i < 8; i++) begin
      repeat (CYCLES_PER_BIT) @(negedge clock);
      rx[i] = txd_o;  // LSB first
    end
    repeat (CYCLES_PER_BIT) @(negedge clock);
    if (txd_o !== 1'b1) report_framing("stop bit not high");
  endtask

  initial begin : serial_monitor
    byte_t rx_byte;
    int idle_cycles;
    idle_cycles = 0;
    forever begin
      @(negedge clock);
      if (usb_reset === 1'b1) begin
        idle_cycles = 0;
      end else if (txd_o === 1'b0) begin
        idle_cycles = 0;
        receive_byte(rx_byte);
        if (exp_chars.size() == 0) report_framing("character sent with none expected");
        else check_char(rx_byte, exp_chars.pop_front());
      end else if (exp_chars.size() != 0) begin
        idle_cycles++;
        if (idle_cycles > GAP_LIMIT) abort_on_stall("waiting for a start bit on txd_o");
      end
    end
  end

  task automatic take_sample();
    logic [31:0] w;
    w = $random(seed);
    @(posedge clock);
    line_state_i <= w[31:30];
    tok_endpt_i  <= w[29:26];
    timeout_i    <= w[25];
    usb_sof_i    <= w[24];
    usb_state_i  <= w[23:20];
    err_code_i   <= w[19:17];
    crc_error_i  <= w[16];
    blk_state_i  <= w[15:8];
    ctl_state_i  <= w[7:4];
    phy_state_i  <= w[3:0];
    sample_i     <= 1'b1;
    if (model_q.size() < TELE_DEPTH) model_q.push_back(w);  // Full buffer drops it
    @(posedge clock);
    sample_i <= 1'b0;
    @(negedge clock);
    check_level(level_o, level_t'(model_q.size()), "level after sample");
  endtask

  task automatic pulse_start();
    @(posedge clock);
    start_i <= 1'b1;
    @(posedge clock);
    start_i <= 1'b0;
  endtask

  task automatic run_dump(input bit restart);
    int cycles;
    int limit;
    logic [71:0] text;
    limit = (model_q.size() * 9 + 2) * 2 * FRAME_CYCLES;
    while (model_q.size() != 0) begin
      text = expected_text(model_q.pop_front());
      for (int i = 8; i >= 0; i--) exp_chars.push_back(text[8*i +: 8]);
    end
    pulse_start();
    @(negedge clock);
    check_flag(dumping_o, 1'b1, "dumping_o after start");
    if (restart) begin
      repeat (3 * FRAME_CYCLES) @(posedge clock);
      pulse_start();  // Must be ignored mid-dump
    end
    cycles = 0;
    while (dumping_o !== 1'b0) begin
      @(negedge clock);
      cycles++;
      if (cycles > limit) abort_on_stall("waiting for dumping_o to fall");
    end
    if (exp_chars.size() != 0) report_framing("dump ended before every character was sent");
    check_level(level_o, '0, "level after dump");
  endtask

  task automatic start_at_empty();
    pulse_start();
    repeat (3 * FRAME_CYCLES) begin
      @(negedge clock);
      check_flag(dumping_o, 1'b0, "dumping_o after start at level 0");
      check_flag(txd_o, 1'b1, "txd_o after start at level 0");
    end
  endtask

  initial begin
    usb_reset = 1'b1;
    sample_i = 1'b0;
    start_i = 1'b0;
    {line_state_i, tok_endpt_i, timeout_i, usb_sof_i, usb_state_i} = '0;
    {err_code_i, crc_error_i, blk_state_i, ctl_state_i, phy_state_i} = '0;
    repeat (2) @(posedge clock);
    usb_reset <= 1'b0;

    repeat (4) begin
      @(negedge clock);
      check_flag(txd_o, 1'b1, "txd_o after reset");
      check_flag(dumping_o, 1'b0, "dumping_o after reset");
      check_level(level_o, '0, "level after reset");
    end

    repeat (5) take_sample();
    run_dump(1'b0);
    repeat (20) take_sample();  // Last four are dropped
    run_dump(1'b1);
    start_at_empty();

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== hdl/usb_tele_top.sv ====
`timescale 1ns/10ps
module usb_tele_top (
  input  logic                 clock,
  input  logic                 usb_reset,
  input  logic                 sample_i,
  input  logic [3:0]           phy_state_i,
  input  logic [3:0]           ctl_state_i,
  input  logic [7:0]           blk_state_i,
  input  logic                 crc_error_i,
  input  logic [2:0]           err_code_i,
  input  logic [3:0]           usb_state_i,
  input  logic                 usb_sof_i,
  input  logic                 timeout_i,
  input  logic [3:0]           tok_endpt_i,
  input  logic [1:0]           line_state_i,
  input  logic                 start_i,
  output logic                 txd_o,
  output logic                 dumping_o,
  output usb_tele_pkg::level_t level_o
);
  import usb_tele_pkg::*;

  tele_word_u word_w;
  level_t level_w;
  byte_t char_w;
  logic pop_w, load_w, busy_w, run_w;
  logic bit_tick_w, frame_done_w;

  assign level_o = level_w;

  telemetry_buffer u_telemetry_buffer (
    .clock       (clock),
    .usb_reset   (usb_reset),
    .sample_i    (sample_i),
    .phy_state_i (phy_state_i),
    .ctl_state_i (ctl_state_i),
    .blk_state_i (blk_state_i),
    .crc_error_i (crc_error_i),
    .err_code_i  (err_code_i),
    .usb_state_i (usb_state_i),
    .usb_sof_i   (usb_sof_i),
    .timeout_i   (timeout_i),
    .tok_endpt_i (tok_endpt_i),
    .line_state_i(line_state_i),
    .pop_i       (pop_w),
    .word_o      (word_w),
    .level_o     (level_w)
  );

  dump_sequencer u_dump_sequencer (
    .clock    (clock),
    .usb_reset(usb_reset),
    .start_i  (start_i),
    .level_i  (level_w),
    .word_i   (word_w),
    .busy_i   (busy_w),
    .pop_o    (pop_w),
    .load_o   (load_w),
    .char_o   (char_w),
    .dumping_o(dumping_o)
  );

  baud_timer u_baud_timer (
    .clock       (clock),
    .usb_reset   (usb_reset),
    .run_i       (run_w),
    .bit_tick_o  (bit_tick_w),
    .frame_done_o(frame_done_w)
  );

  uart_tx u_uart_tx (
    .clock       (clock),
    .usb_reset   (usb_reset),
    .load_i      (load_w),
    .char_i      (char_w),
    .bit_tick_i  (bit_tick_w),
    .frame_done_i(frame_done_w),
    .run_o       (run_w),
    .busy_o      (busy_w),
    .txd_o       (txd_o)
  );

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/10ps
module uart_tx (
  input  logic                clock,
  input  logic                usb_reset,
  input  logic                load_i,
  input  usb_tele_pkg::byte_t char_i,
  input  logic                bit_tick_i,
  input  logic                frame_done_i,
  output logic                run_o,
  output logic                busy_o,
  output logic                txd_o
);
  import usb_tele_pkg::*;

  logic [FRAME_BITS-1:0] frame_q;
  logic busy_q;

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      busy_q <= 1'b0;
    end else if (load_i) begin
      busy_q <= 1'b1;
    end else if (frame_done_i) begin
      busy_q <= 1'b0;
    end
  end

  // Shift register whose LSB is the line level
  always_ff @(posedge clock) begin
    if (usb_reset) begin
      frame_q <= '1;  // Line idles high
    end else if (load_i) begin
      frame_q <= {1'b1, char_i, 1'b0};  // Stop, data, start
    end else if (bit_tick_i) begin
      frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};  // Ones back-fill
    end
  end

  assign busy_o = busy_q;
  assign run_o  = busy_q;  // Timer runs for the whole frame
  assign txd_o  = frame_q[0];

  // Timer must only finish frames this transmitter started
  a_done_in_frame: assert property (@(posedge clock) disable iff (usb_reset)
    frame_done_i |-> busy_q)
    else $error("frame end outside of a frame");

endmodule

// ==== hdl/baud_timer.sv ====
`timescale 1ns/10ps
module baud_timer (
  input  logic clock,
  input  logic usb_reset,
  input  logic run_i,
  output logic bit_tick_o,
  output logic frame_done_o
);
  import usb_tele_pkg::*;

  logic [$clog2(CYCLES_PER_BIT)-1:0] cyc_q;
  logic [$clog2(FRAME_BITS)-1:0] bit_q;
  logic last_cyc_w, last_bit_w;

  assign last_cyc_w = (cyc_q == ($bits(cyc_q))'(CYCLES_PER_BIT - 1));
  assign last_bit_w = (bit_q == ($bits(bit_q))'(FRAME_BITS - 1));

  always_ff @(posedge clock) begin
    if (usb_reset || !run_i) begin  // Held clear between frames
      cyc_q <= '0;
      bit_q <= '0;
    end else if (last_cyc_w) begin
      cyc_q <= '0;
      bit_q <= last_bit_w ? '0 : bit_q + 1'b1;
    end else begin
      cyc_q <= cyc_q + 1'b1;
    end
  end

  assign bit_tick_o   = run_i && last_cyc_w;
  assign frame_done_o = bit_tick_o && last_bit_w;  // End of stop bit

endmodule

// ==== hdl/dump_sequencer.sv ====
`timescale 1ns/10ps
module dump_sequencer (
  input  logic                     clock,
  input  logic                     usb_reset,
  input  logic                     start_i,
  input  usb_tele_pkg::level_t     level_i,
  input  usb_tele_pkg::tele_word_u word_i,
  input  logic                     busy_i,
  output logic                     pop_o,
  output logic                     load_o,
  output usb_tele_pkg::byte_t      char_o,
  output logic                     dumping_o
);
  import usb_tele_pkg::*;

  logic [2:0] state_q;
  logic [2:0] nib_idx_q;
  tele_word_u word_q;
  byte_t char_q;
  logic load_q;
  logic dumping_q;
  logic send_ok_w;

  // Transmitter idle and no load still in flight
  assign send_ok_w = !busy_i && !load_q;

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      state_q   <= SEQ_IDLE;
      nib_idx_q <= '0;
      load_q    <= 1'b0;
      dumping_q <= 1'b0;
    end else begin
      load_q <= 1'b0;  // Single-cycle strobe
      case (state_q)
        SEQ_IDLE: begin
          if (start_i && level_i != '0) begin
            state_q   <= SEQ_LATCH;
            dumping_q <= 1'b1;
          end
        end
        SEQ_LATCH: begin
          nib_idx_q <= 3'(CHARS_PER_WORD - 1);  // MS nibble first
          state_q   <= SEQ_NIBBLE;
        end
        SEQ_NIBBLE: begin
          if (send_ok_w) begin
            load_q <= 1'b1;
            if (nib_idx_q == '0) state_q <= SEQ_EOL;
            else nib_idx_q <= nib_idx_q - 1'b1;
          end
        end
        SEQ_EOL: begin
          if (send_ok_w) begin
            load_q  <= 1'b1;
            state_q <= (level_i != '0) ? SEQ_LATCH : SEQ_DRAIN;
          end
        end
        SEQ_DRAIN: begin
          // Wait out the final line-end frame
          if (send_ok_w) begin
            state_q   <= SEQ_IDLE;
            dumping_q <= 1'b0;
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  // Word and character registers
  always_ff @(posedge clock) begin
    if (state_q == SEQ_LATCH) word_q <= word_i;
    if (send_ok_w) begin
      if (state_q == SEQ_NIBBLE) char_q <= hex_char(word_q.nibbles[nib_idx_q]);
      else if (state_q == SEQ_EOL) char_q <= LINE_END;
    end
  end

  assign pop_o     = (state_q == SEQ_LATCH);  // Once per word
  assign load_o    = load_q;
  assign char_o    = char_q;
  assign dumping_o = dumping_q;

  // Registered load must never overlap a frame in progress
  a_no_load_busy: assert property (@(posedge clock) disable iff (usb_reset)
    load_o |-> !busy_i)
    else $error("character load while transmitter busy");

endmodule

// ==== hdl/telemetry_buffer.sv ====
`timescale 1ns/10ps
module telemetry_buffer (
  input  logic                     clock,
  input  logic                     usb_reset,
  input  logic                     sample_i,
  input  logic [3:0]               phy_state_i,
  input  logic [3:0]               ctl_state_i,
  input  logic [7:0]               blk_state_i,
  input  logic                     crc_error_i,
  input  logic [2:0]               err_code_i,
  input  logic [3:0]               usb_state_i,
  input  logic                     usb_sof_i,
  input  logic                     timeout_i,
  input  logic [3:0]               tok_endpt_i,
  input  logic [1:0]               line_state_i,
  input  logic                     pop_i,
  output usb_tele_pkg::tele_word_u word_o,
  output usb_tele_pkg::level_t     level_o
);
  import usb_tele_pkg::*;

  tele_word_u mem_q [TELE_DEPTH];  // Word storage
  tele_word_u sample_w;
  logic [PTR_BITS-1:0] wr_ptr_q, rd_ptr_q;
  level_t level_q;
  logic push_w;

  // Pack the status inputs through the fields view
  always_comb begin
    sample_w.fields.line_state = line_state_i;
    sample_w.fields.tok_endpt  = tok_endpt_i;
    sample_w.fields.timeout    = timeout_i;
    sample_w.fields.usb_sof    = usb_sof_i;
    sample_w.fields.usb_state  = usb_state_i;
    sample_w.fields.err_code   = err_code_i;
    sample_w.fields.crc_error  = crc_error_i;
    sample_w.fields.blk_state  = blk_state_i;
    sample_w.fields.ctl_state  = ctl_state_i;
    sample_w.fields.phy_state  = phy_state_i;
  end

  assign push_w = sample_i && (level_q != level_t'(TELE_DEPTH));  // Drop when full

  always_ff @(posedge clock) begin
    if (push_w) mem_q[wr_ptr_q] <= sample_w;
  end

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push_w) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
      if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_w, pop_i})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;  // Both or neither
      endcase
    end
  end

  assign word_o  = mem_q[rd_ptr_q];  // Oldest word
  assign level_o = level_q;

  // The sequencer only pops words it has seen in the buffer
  a_no_pop_empty: assert property (@(posedge clock) disable iff (usb_reset)
    pop_i |-> (level_q != '0))
    else $error("pop while telemetry buffer is empty");

endmodule

// ==== hdl/usb_tele_pkg.sv ====
package usb_tele_pkg;

  // Buffer geometry
  localparam int TELE_DEPTH = 16;
  localparam int LEVEL_BITS = 5;  // Counts 0 to TELE_DEPTH inclusive
  localparam int PTR_BITS = 4;

  // UART framing with a short bit period for simulation
  localparam int CYCLES_PER_BIT = 16;
  localparam int FRAME_BITS = 10;  // Start, 8 data, stop

  // Print format
  localparam int CHARS_PER_WORD = 8;
  localparam logic [7:0] LINE_END = 8'h0A;

  // Dump sequencer states
  localparam logic [2:0] SEQ_IDLE = 3'd0;
  localparam logic [2:0] SEQ_LATCH = 3'd1;
  localparam logic [2:0] SEQ_NIBBLE = 3'd2;
  localparam logic [2:0] SEQ_EOL = 3'd3;
  localparam logic [2:0] SEQ_DRAIN = 3'd4;

  typedef logic [LEVEL_BITS-1:0] level_t;
  typedef logic [7:0] byte_t;

  // Status fields from the MSB down
  typedef struct packed {
    logic [1:0] line_state;
    logic [3:0] tok_endpt;
    logic       timeout;
    logic       usb_sof;
    logic [3:0] usb_state;
    logic [2:0] err_code;
    logic       crc_error;
    logic [7:0] blk_state;
    logic [3:0] ctl_state;
    logic [3:0] phy_state;
  } tele_fields_t;

  // Captured as fields, printed as nibbles
  typedef union packed {
    tele_fields_t                         fields;
    logic [CHARS_PER_WORD-1:0][3:0] nibbles;
  } tele_word_u;

  // Upper-case ASCII hex digit
  function automatic byte_t hex_char(input logic [3:0] nib);
    if (nib < 4'd10) return 8'h30 + {4'h0, nib};
    else return 8'h37 + {4'h0, nib};
  endfunction

endpackage
